//--- flist.f
+incdir+rtl
+incdir+verif
rtl/pe_bus_pkg.sv
rtl/pe_addr_decode.sv
rtl/pe_rtc.sv
rtl/pe_plic.sv
rtl/pe_read_return.sv
rtl/pe_periph_top.sv
verif/tb_pe_periph.sv

//--- Bender.yml
package:
  name: pe_periph

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pe_bus_pkg.sv
      - rtl/pe_addr_decode.sv
      - rtl/pe_rtc.sv
      - rtl/pe_plic.sv
      - rtl/pe_read_return.sv
      - rtl/pe_periph_top.sv
  - target: simulation
    include_dirs:
      - rtl
      - verif
    files:
      - verif/tb_pe_periph.sv

//--- verif/tb_pe_tasks.svh
`ifndef TB_PE_TASKS_SVH
`define TB_PE_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// Bus access called and returning on a falling edge
//////////////////////////////////////////////////////////////////////

task automatic bus_access(input logic [3:0] we, input pe_bus_pkg::addr_t addr,
                          input pe_bus_pkg::data_t wdata,
                          output pe_bus_pkg::mem_req_t mem_seen,
                          output pe_bus_pkg::data_t rdata_seen);
    bus_req.en    = 1'b1;
    bus_req.we    = we;
    bus_req.addr  = addr;
    bus_req.wdata = wdata;
    @(posedge clk_i);
    mem_seen = dmem_req;
    @(negedge clk_i);
    rdata_seen = rdata;
    bus_req    = '0;
endtask

task automatic reg_write(input pe_bus_pkg::addr_t addr, input pe_bus_pkg::data_t wdata);
    pe_bus_pkg::mem_req_t seen;
    pe_bus_pkg::data_t    rd;
    bus_access(4'hF, addr, wdata, seen, rd);
endtask

task automatic reg_read(input pe_bus_pkg::addr_t addr, output pe_bus_pkg::data_t rd);
    pe_bus_pkg::mem_req_t seen;
    bus_access(4'h0, addr, '0, seen, rd);
endtask

//////////////////////////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////////////////////////

task automatic test_reset_state();
    check_value("mti_o", mti, 1'b0);
    check_value("mei_o", mei, 1'b0);
    check_value("dmem_o.en", dmem_req.en, 1'b0);
endtask

task automatic test_decode_dmem();
    pe_bus_pkg::addr_t    addr;
    pe_bus_pkg::data_t    wdata;
    pe_bus_pkg::data_t    rd;
    pe_bus_pkg::mem_req_t seen;
    logic [7:0]           others [0:2];
    others[0] = `PE_REGION_RTC;
    others[1] = `PE_REGION_PLIC;
    others[2] = 8'h08;
    addr  = make_addr(`PE_REGION_DMEM, lcg_next());
    wdata = lcg_next();
    bus_access(4'hF, addr, wdata, seen, rd);
    check_value("dmem_o.en", seen.en, 1'b1);
    check_value("dmem_o.we", seen.we, 4'hF);
    check_value("dmem_o.addr", seen.addr, addr[`PE_MEM_ADDR_W-1:0]);
    check_value("dmem_o.wdata", seen.wdata, wdata);
    bus_access(4'h0, addr, '0, seen, rd);
    check_value("dmem_o.en", seen.en, 1'b1);
    check_value("rdata_o", rd, mem_word(addr[`PE_MEM_ADDR_W-1:0]));
    // Reads only, so register state is left alone
    for (int i = 0; i < 3; i++) begin
        addr = make_addr(others[i], lcg_next());
        bus_access(4'h0, addr, '0, seen, rd);
        check_value("dmem_o.en", seen.en, 1'b0);
    end
    check_value("rdata_o unmapped", rd, mem_word(addr[`PE_MEM_ADDR_W-1:0]));
endtask

task automatic test_rtc_count();
    pe_bus_pkg::addr_t lo_addr;
    pe_bus_pkg::data_t t0;
    pe_bus_pkg::data_t t1;
    pe_bus_pkg::data_t delta;
    pe_bus_pkg::data_t wval;
    pe_bus_pkg::data_t t_exp;
    int unsigned       idle;
    lo_addr = make_addr(`PE_REGION_RTC, `PE_RTC_MTIME_LO);
    reg_read(lo_addr, t0);
    idle = 3 + (lcg_next() % 16);
    repeat (idle) @(negedge clk_i);
    reg_read(lo_addr, t1);
    // Second request comes idle+1 cycles after the first
    delta = t1 - t0;
    check_value("mtime delta", delta, idle + 1);
    wval = lcg_next();
    reg_write(lo_addr, wval);
    idle = 2 + (lcg_next() % 8);
    repeat (idle) @(negedge clk_i);
    reg_read(lo_addr, t1);
    // Low word wraps like the counter does
    t_exp = wval + idle;
    check_value("mtime after write", t1, t_exp);
endtask

task automatic test_timer_irq();
    int unsigned offset_d;
    int unsigned limit;
    int unsigned rise;
    offset_d = 2 + (lcg_next() % 6);
    limit    = offset_d + 8;
    reg_write(make_addr(`PE_REGION_RTC, `PE_RTC_MTIME_HI), 32'h0);
    reg_write(make_addr(`PE_REGION_RTC, `PE_RTC_MTIME_LO), 32'h0);
    reg_write(make_addr(`PE_REGION_RTC, `PE_RTC_CMP_LO), 2 + offset_d);
    reg_write(make_addr(`PE_REGION_RTC, `PE_RTC_CMP_HI), 32'h0);
    // Two cycles since mtime landed at zero
    check_value("mtime_o", mtime, 64'd2);
    check_value("mti_o", mti, 1'b0);
    rise = 0;
    while (!mti && rise <= limit) begin
        @(negedge clk_i);
        rise++;
    end
    if (!mti) begin
        abort_run($sformatf("Timeout: mti_o did not rise within %0d cycles", limit));
    end
    check_value("mti_o rise cycles", rise, offset_d);
    repeat (4) begin
        @(negedge clk_i);
        check_value("mti_o", mti, 1'b1);
    end
    reg_write(make_addr(`PE_REGION_RTC, `PE_RTC_CMP_HI), 32'hFFFF_FFFF);
    check_value("mti_o", mti, 1'b0);
endtask

task automatic test_ext_irq();
    pe_bus_pkg::addr_t claim_addr;
    pe_bus_pkg::addr_t enable_addr;
    pe_bus_pkg::data_t rd;
    claim_addr  = make_addr(`PE_REGION_PLIC, `PE_PLIC_CLAIM);
    enable_addr = make_addr(`PE_REGION_PLIC, `PE_PLIC_ENABLE);
    irq_src = 1'b1;
    @(negedge clk_i);
    irq_src = 1'b0;
    check_value("mei_o", mei, 1'b0);
    reg_read(claim_addr, rd);
    check_value("claim", rd, 32'd0);
    reg_write(enable_addr, 32'd1);
    check_value("mei_o", mei, 1'b1);
    reg_read(claim_addr, rd);
    check_value("claim", rd, 32'd1);
    reg_read(enable_addr, rd);
    check_value("enable", rd, 32'd1);
    iack = 1'b1;
    @(negedge clk_i);
    iack = 1'b0;
    check_value("mei_o", mei, 1'b0);
    reg_read(claim_addr, rd);
    check_value("claim", rd, 32'd0);
endtask

`endif

//--- verif/tb_pe_periph.sv
`default_nettype none

`include "pe_bus_params.svh"

module tb_pe_periph;

    localparam int unsigned CLK_PERIOD  = 8;
    localparam int unsigned RST_CYCLES  = 8;
    localparam logic [31:0] LCG_SEED    = 32'h5af3b1c1;
    localparam logic [31:0] MEM_PATTERN = 32'hA5A5A5A5;

    logic                    clk_i;
    logic                    rst_ni;
    pe_bus_pkg::bus_req_t    bus_req;
    logic                    irq_src;
    logic                    iack;
    pe_bus_pkg::mem_req_t    dmem_req;
    pe_bus_pkg::data_t       dmem_rdata;
    pe_bus_pkg::data_t       rdata;
    logic                    mti;
    logic                    mei;
    pe_bus_pkg::tick_t       mtime;

    logic [31:0] lcg_state;

    pe_periph_top dut_i (
        .clk_i        (clk_i     ),
        .rst_ni       (rst_ni    ),
        .bus_req_i    (bus_req   ),
        .rdata_o      (rdata     ),
        .irq_src_i    (irq_src   ),
        .iack_i       (iack      ),
        .dmem_o       (dmem_req  ),
        .dmem_rdata_i (dmem_rdata),
        .mti_o        (mti       ),
        .mei_o        (mei       ),
        .mtime_o      (mtime     )
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Region code on top, low bits of offset below
    function automatic pe_bus_pkg::addr_t make_addr(input logic [7:0] region,
                                                    input logic [31:0] offset);
        return {region, offset[`PE_MEM_ADDR_W-1:0]};
    endfunction

    // Zero-extended port address XOR a fixed pattern
    function automatic pe_bus_pkg::data_t mem_word(input pe_bus_pkg::mem_addr_t addr);
        return {{(`PE_DATA_W-`PE_MEM_ADDR_W){1'b0}}, addr} ^ MEM_PATTERN;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: %s = 0x%0h, expected 0x%0h",
                                $time, name, got, exp));
        end
    endtask

    // Memory answers every cycle one cycle late
    always @(posedge clk_i) begin
        dmem_rdata <= mem_word(dmem_req.addr);
    end

    `include "tb_pe_tasks.svh"

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        lcg_state  = LCG_SEED;
        rst_ni     = 1'b0;
        bus_req    = '0;
        irq_src    = 1'b0;
        iack       = 1'b0;
        dmem_rdata = '0;
        repeat (RST_CYCLES) @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i);

        test_reset_state();
        test_decode_dmem();
        test_rtc_count();
        test_timer_irq();
        test_ext_irq();

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/pe_periph_top.sv
`default_nettype none

module pe_periph_top (
    input  logic                 clk_i,
    input  logic                 rst_ni,

    // Processor bus
    input  pe_bus_pkg::bus_req_t bus_req_i,
    output pe_bus_pkg::data_t    rdata_o,

    // Interrupt source and acknowledge
    input  logic                 irq_src_i,
    input  logic                 iack_i,

    // Data memory port
    output pe_bus_pkg::mem_req_t dmem_o,
    input  pe_bus_pkg::data_t    dmem_rdata_i,

    // Interrupts and time to the core
    output logic                 mti_o,
    output logic                 mei_o,
    output pe_bus_pkg::tick_t    mtime_o
);

    pe_bus_pkg::periph_sel_t sel;
    pe_bus_pkg::data_t       rtc_rdata;
    pe_bus_pkg::data_t       plic_rdata;

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////

    pe_addr_decode decode_i (
        .bus_req_i (bus_req_i),
        .sel_o     (sel      ),
        .dmem_o    (dmem_o   )
    );

    //////////////////////////////////////////////////////////////////////
    // Register blocks
    //////////////////////////////////////////////////////////////////////

    pe_rtc rtc_i (
        .clk_i     (clk_i    ),
        .rst_ni    (rst_ni   ),
        .sel_i     (sel.rtc  ),
        .bus_req_i (bus_req_i),
        .rdata_o   (rtc_rdata),
        .mtime_o   (mtime_o  ),
        .mti_o     (mti_o    )
    );

    pe_plic plic_i (
        .clk_i     (clk_i     ),
        .rst_ni    (rst_ni    ),
        .sel_i     (sel.plic  ),
        .bus_req_i (bus_req_i ),
        .irq_src_i (irq_src_i ),
        .iack_i    (iack_i    ),
        .rdata_o   (plic_rdata),
        .mei_o     (mei_o     )
    );

    //////////////////////////////////////////////////////////////////////
    // Read return
    //////////////////////////////////////////////////////////////////////

    pe_read_return read_return_i (
        .clk_i        (clk_i       ),
        .rst_ni       (rst_ni      ),
        .sel_i        (sel         ),
        .rtc_rdata_i  (rtc_rdata   ),
        .plic_rdata_i (plic_rdata  ),
        .dmem_rdata_i (dmem_rdata_i),
        .rdata_o      (rdata_o     )
    );

endmodule

`default_nettype wire

//--- rtl/pe_read_return.sv
`default_nettype none

module pe_read_return (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  pe_bus_pkg::periph_sel_t sel_i,
    input  pe_bus_pkg::data_t       rtc_rdata_i,
    input  pe_bus_pkg::data_t       plic_rdata_i,
    input  pe_bus_pkg::data_t       dmem_rdata_i,
    output pe_bus_pkg::data_t       rdata_o
);

    //////////////////////////////////////////////////////////////////////
    // Target of the previous request
    //////////////////////////////////////////////////////////////////////

    pe_bus_pkg::periph_sel_t sel_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sel_q <= '0;
        end else begin
            sel_q <= sel_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Return mux
    //////////////////////////////////////////////////////////////////////

    // Memory is the default, so unmapped reads see memory data
    always_comb begin
        if (sel_q.rtc) begin
            rdata_o = rtc_rdata_i;
        end else if (sel_q.plic) begin
            rdata_o = plic_rdata_i;
        end else begin
            rdata_o = dmem_rdata_i;
        end
    end

endmodule

`default_nettype wire

//--- rtl/pe_plic.sv
`default_nettype none

`include "pe_bus_params.svh"

module pe_plic (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 sel_i,
    input  pe_bus_pkg::bus_req_t bus_req_i,
    input  logic                 irq_src_i,
    input  logic                 iack_i,
    output pe_bus_pkg::data_t    rdata_o,
    output logic                 mei_o
);

    logic [3:0] offset;
    logic       wr_en;
    logic       pending_q;
    logic       enable_q;
    logic       active;

    pe_bus_pkg::data_t rd_word;

    assign offset = bus_req_i.addr[3:0];
    assign wr_en  = sel_i && (|bus_req_i.we);
    assign active = pending_q && enable_q;

    //////////////////////////////////////////////////////////////////////
    // Pending and enable
    //////////////////////////////////////////////////////////////////////

    // Acknowledge takes priority over a new request
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else if (iack_i) begin
            pending_q <= 1'b0;
        end else if (irq_src_i) begin
            pending_q <= 1'b1;
        end
    end

    // Only bit 0 exists, any strobe writes it
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_q <= 1'b0;
        end else if (wr_en && (offset == `PE_PLIC_ENABLE)) begin
            enable_q <= bus_req_i.wdata[0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (offset)
            `PE_PLIC_ENABLE: rd_word = {{(`PE_DATA_W-1){1'b0}}, enable_q};
            // Claim gives the source id only when it would interrupt
            `PE_PLIC_CLAIM:  rd_word = active ? `PE_PLIC_SRC_ID : '0;
            default:         rd_word = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (sel_i) begin
            rdata_o <= rd_word;
        end
    end

    assign mei_o = active;

endmodule

`default_nettype wire

//--- rtl/pe_rtc.sv
`default_nettype none

`include "pe_bus_params.svh"

module pe_rtc (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 sel_i,
    input  pe_bus_pkg::bus_req_t bus_req_i,
    output pe_bus_pkg::data_t    rdata_o,
    output pe_bus_pkg::tick_t    mtime_o,
    output logic                 mti_o
);

    // Byte-wise merge of a write into one register word
    function automatic pe_bus_pkg::data_t merge_bytes(
        input pe_bus_pkg::data_t old_word,
        input pe_bus_pkg::data_t new_word,
        input pe_bus_pkg::strb_t strb
    );
        pe_bus_pkg::data_t word;
        word = old_word;
        for (int i = 0; i < `PE_STRB_W; i++) begin
            if (strb[i]) begin
                word[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return word;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Register access decode
    //////////////////////////////////////////////////////////////////////

    logic [3:0] offset;
    logic       wr_en;

    pe_bus_pkg::tick_t mtime_q;
    pe_bus_pkg::tick_t mtime_d;
    pe_bus_pkg::tick_t cmp_q;
    pe_bus_pkg::tick_t cmp_d;
    pe_bus_pkg::data_t rd_word;

    assign offset = bus_req_i.addr[3:0];
    assign wr_en  = sel_i && (|bus_req_i.we);

    //////////////////////////////////////////////////////////////////////
    // Tick counter and compare
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        mtime_d = mtime_q + pe_bus_pkg::tick_t'(1);
        cmp_d   = cmp_q;
        if (wr_en) begin
            case (offset)
                // A write to either half takes the place of the increment
                `PE_RTC_MTIME_LO: mtime_d = {mtime_q[`PE_TICK_W-1:`PE_DATA_W],
                    merge_bytes(mtime_q[`PE_DATA_W-1:0], bus_req_i.wdata, bus_req_i.we)};
                `PE_RTC_MTIME_HI: mtime_d = {
                    merge_bytes(mtime_q[`PE_TICK_W-1:`PE_DATA_W], bus_req_i.wdata, bus_req_i.we),
                    mtime_q[`PE_DATA_W-1:0]};
                `PE_RTC_CMP_LO:   cmp_d = {cmp_q[`PE_TICK_W-1:`PE_DATA_W],
                    merge_bytes(cmp_q[`PE_DATA_W-1:0], bus_req_i.wdata, bus_req_i.we)};
                `PE_RTC_CMP_HI:   cmp_d = {
                    merge_bytes(cmp_q[`PE_TICK_W-1:`PE_DATA_W], bus_req_i.wdata, bus_req_i.we),
                    cmp_q[`PE_DATA_W-1:0]};
                default: ;
            endcase
        end
    end

    // Compare starts at all ones so the timer is quiet out of reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtime_q <= '0;
            cmp_q   <= '1;
        end else begin
            mtime_q <= mtime_d;
            cmp_q   <= cmp_d;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (offset)
            `PE_RTC_MTIME_LO: rd_word = mtime_q[`PE_DATA_W-1:0];
            `PE_RTC_MTIME_HI: rd_word = mtime_q[`PE_TICK_W-1:`PE_DATA_W];
            `PE_RTC_CMP_LO:   rd_word = cmp_q[`PE_DATA_W-1:0];
            `PE_RTC_CMP_HI:   rd_word = cmp_q[`PE_TICK_W-1:`PE_DATA_W];
            default:          rd_word = '0;
        endcase
    end

    // Value before any write of the same cycle
    always_ff @(posedge clk_i) begin
        if (sel_i) begin
            rdata_o <= rd_word;
        end
    end

    assign mtime_o = mtime_q;
    assign mti_o   = (mtime_q >= cmp_q);

endmodule

`default_nettype wire

//--- rtl/pe_addr_decode.sv
`default_nettype none

`include "pe_bus_params.svh"

module pe_addr_decode (
    input  pe_bus_pkg::bus_req_t    bus_req_i,
    output pe_bus_pkg::periph_sel_t sel_o,
    output pe_bus_pkg::mem_req_t    dmem_o
);

    //////////////////////////////////////////////////////////////////////
    // Region match
    //////////////////////////////////////////////////////////////////////

    logic [`PE_REGION_HI-`PE_REGION_LO:0] region;

    logic hit_dmem;
    logic hit_rtc;
    logic hit_plic;

    assign region = bus_req_i.addr[`PE_REGION_HI:`PE_REGION_LO];

    // One-hot codes, anything else falls through to nothing
    assign hit_dmem = (region == `PE_REGION_DMEM);
    assign hit_rtc  = (region == `PE_REGION_RTC);
    assign hit_plic = (region == `PE_REGION_PLIC);

    //////////////////////////////////////////////////////////////////////
    // Peripheral selects
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        sel_o      = '0;
        sel_o.rtc  = bus_req_i.en && hit_rtc;
        sel_o.plic = bus_req_i.en && hit_plic;
    end

    //////////////////////////////////////////////////////////////////////
    // Data memory port
    //////////////////////////////////////////////////////////////////////

    // Strobes and data pass through, memory ignores them unless en
    always_comb begin
        dmem_o.en    = bus_req_i.en && hit_dmem;
        dmem_o.we    = bus_req_i.we;
        dmem_o.addr  = bus_req_i.addr[`PE_MEM_ADDR_W-1:0];
        dmem_o.wdata = bus_req_i.wdata;
    end

endmodule

`default_nettype wire

//--- rtl/pe_bus_pkg.sv
`default_nettype none

`include "pe_bus_params.svh"

package pe_bus_pkg;

    //////////////////////////////////////////////////////////////////////
    // Plain vector types
    //////////////////////////////////////////////////////////////////////

    typedef logic [`PE_ADDR_W-1:0]     addr_t;
    typedef logic [`PE_DATA_W-1:0]     data_t;
    typedef logic [`PE_STRB_W-1:0]     strb_t;
    typedef logic [`PE_MEM_ADDR_W-1:0] mem_addr_t;

    // Free-running tick count, two bus words
    typedef logic [`PE_TICK_W-1:0]     tick_t;

    //////////////////////////////////////////////////////////////////////
    // Bus structs
    //////////////////////////////////////////////////////////////////////

    // Processor-side request, valid whenever en is high
    typedef struct packed {
        logic  en;
        strb_t we;
        addr_t addr;
        data_t wdata;
    } bus_req_t;

    // One select per register block
    typedef struct packed {
        logic rtc;
        logic plic;
    } periph_sel_t;

    // Data memory port, address trimmed to the region offset
    typedef struct packed {
        logic      en;
        strb_t     we;
        mem_addr_t addr;
        data_t     wdata;
    } mem_req_t;

endpackage

`default_nettype wire

//--- rtl/pe_bus_params.svh
`ifndef PE_BUS_PARAMS_SVH
`define PE_BUS_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////////////////////////

`define PE_ADDR_W      32
`define PE_DATA_W      32
`define PE_STRB_W      (`PE_DATA_W / 8)
`define PE_TICK_W      64
`define PE_MEM_ADDR_W  24

//////////////////////////////////////////////////////////////////////
// Memory map
//////////////////////////////////////////////////////////////////////

// Region field of the address
`define PE_REGION_HI   31
`define PE_REGION_LO   24

`define PE_REGION_DMEM 8'h01
`define PE_REGION_RTC  8'h02
`define PE_REGION_PLIC 8'h04

// RTC word offsets, address bits 3:0
`define PE_RTC_MTIME_LO 4'h0
`define PE_RTC_MTIME_HI 4'h4
`define PE_RTC_CMP_LO   4'h8
`define PE_RTC_CMP_HI   4'hC

// PLIC offsets, address bits 3:0
`define PE_PLIC_ENABLE  4'h0
`define PE_PLIC_CLAIM   4'h4
`define PE_PLIC_SRC_ID  32'd1

`endif
